// ==== logic/blob_pkg.sv ====
package blob_pkg;

    // label 0 is background
    localparam int LABEL_W    = 8;
    localparam int NUM_LABELS = 1 << LABEL_W;
    localparam int AREA_W     = 15;
    localparam int COUNT_W    = 8;

    typedef logic [LABEL_W-1:0] label_t;
    typedef logic [AREA_W-1:0]  area_t;
    typedef logic [COUNT_W-1:0] count_t;

    // tally sequencer states, in scan order
    typedef enum logic [2:0] {
        TALLY_IDLE,
        TALLY_MERGE,
        TALLY_MAX,
        TALLY_COUNT,
        TALLY_OUT
    } tally_state_e;

endpackage

// ==== logic/label_stream.sv ====
module label_stream import blob_pkg::*; #(
    parameter int IMG_COL = 640
) (
    input  logic   i_clk,
    input  logic   i_rst_n,
    input  logic   i_valid,
    input  logic   i_seq,
    input  logic   i_busy,
    output logic   o_new_we,
    output logic   o_inc_we,
    output logic   o_union_we,
    output logic   o_frame_end,
    output label_t o_new_label,
    output label_t o_inc_label,
    output label_t o_union_hi,
    output label_t o_union_lo
);

    localparam int COL_W = $clog2(IMG_COL);

    label_t           row_buf [IMG_COL];   // labels of the row above
    label_t           left_q;
    logic [COL_W-1:0] col_q;
    logic             first_row_q;
    label_t           next_lbl_q;
    logic             lbl_full_q;          // label 255 already handed out
    logic             in_frame_q;

    logic   accept;
    label_t up_lbl;
    label_t left_lbl;
    label_t nb_lbl;
    label_t hi_lbl;
    label_t cur_lbl;
    logic   has_nb;
    logic   both_nb;

    assign accept = i_valid && !i_busy;

    // neighbours outside the frame read as background
    assign up_lbl   = first_row_q ? '0 : row_buf[col_q];
    assign left_lbl = (col_q == '0) ? '0 : left_q;

    assign has_nb  = (up_lbl != '0) || (left_lbl != '0);
    assign both_nb = (up_lbl != '0) && (left_lbl != '0);

    always_comb begin
        if (both_nb) begin
            nb_lbl = (up_lbl < left_lbl) ? up_lbl : left_lbl;
            hi_lbl = (up_lbl < left_lbl) ? left_lbl : up_lbl;
        end else begin
            nb_lbl = up_lbl | left_lbl;    // only one is nonzero
            hi_lbl = up_lbl | left_lbl;
        end
    end

    assign cur_lbl = !i_seq ? '0 : (has_nb ? nb_lbl : next_lbl_q);

    assign o_frame_end = in_frame_q && !i_valid;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            col_q       <= '0;
            first_row_q <= 1'b1;
            next_lbl_q  <= label_t'(1);
            lbl_full_q  <= 1'b0;
            in_frame_q  <= 1'b0;
            o_new_we    <= 1'b0;
            o_inc_we    <= 1'b0;
            o_union_we  <= 1'b0;
        end else begin
            in_frame_q <= accept;
            o_new_we   <= accept && i_seq && !has_nb && !lbl_full_q;
            o_inc_we   <= accept && i_seq && (has_nb || lbl_full_q);
            o_union_we <= accept && i_seq && both_nb && (up_lbl != left_lbl);
            if (accept) begin
                if (col_q == COL_W'(IMG_COL - 1)) begin
                    col_q       <= '0;
                    first_row_q <= 1'b0;
                end else begin
                    col_q <= col_q + 1'b1;
                end
                if (i_seq && !has_nb && !lbl_full_q) begin
                    if (next_lbl_q == '1) begin
                        lbl_full_q <= 1'b1;    // 255 is reused from now on
                    end else begin
                        next_lbl_q <= next_lbl_q + 1'b1;
                    end
                end
            end
            if (o_frame_end) begin
                col_q       <= '0;
                first_row_q <= 1'b1;
                next_lbl_q  <= label_t'(1);
                lbl_full_q  <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            row_buf[col_q] <= cur_lbl;
            left_q         <= cur_lbl;
            o_new_label    <= next_lbl_q;
            o_inc_label    <= cur_lbl;
            o_union_hi     <= hi_lbl;
            o_union_lo     <= nb_lbl;
        end
    end

    // the tally owns the table while busy
    a_no_write_busy: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_busy |-> !(o_new_we || o_inc_we || o_union_we));

    a_new_inc_excl: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $onehot0({o_new_we, o_inc_we}));

endmodule

// ==== logic/label_table.sv ====
module label_table import blob_pkg::*; (
    input  logic   i_clk,
    input  logic   i_rst_n,
    input  logic   i_new_we,
    input  label_t i_new_label,
    input  logic   i_inc_we,
    input  label_t i_inc_label,
    input  logic   i_union_we,
    input  label_t i_union_hi,
    input  label_t i_union_lo,
    input  label_t i_scan_addr,
    input  logic   i_merge_we,
    input  logic   i_clear_we,
    output label_t o_scan_parent,
    output area_t  o_scan_area
);

    label_t parent_q [NUM_LABELS];
    area_t  area_q   [NUM_LABELS];

    logic union_ok;
    logic fold_ok;

    assign o_scan_parent = parent_q[i_scan_addr];
    assign o_scan_area   = area_q[i_scan_addr];

    // only a root may be given a new parent
    assign union_ok = parent_q[i_union_hi] == i_union_hi;

    // roots and unused entries keep their area
    assign fold_ok = (o_scan_parent != i_scan_addr) && (o_scan_parent != '0);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < NUM_LABELS; i++) begin
                parent_q[i] <= '0;
                area_q[i]   <= '0;
            end
        end else begin
            if (i_new_we) begin
                parent_q[i_new_label] <= i_new_label;
                area_q[i_new_label]   <= area_t'(1);
            end
            if (i_inc_we) begin
                area_q[i_inc_label] <= area_q[i_inc_label] + 1'b1;
            end
            if (i_union_we && union_ok) begin
                parent_q[i_union_hi] <= i_union_lo;
            end
            if (i_merge_we && fold_ok) begin
                area_q[o_scan_parent] <= area_q[o_scan_parent] + o_scan_area;
                area_q[i_scan_addr]   <= '0;
            end
            if (i_clear_we) begin
                parent_q[i_scan_addr] <= '0;
                area_q[i_scan_addr]   <= '0;
            end
        end
    end

    // descending merge relies on parents sitting below their label
    a_merge_down: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_merge_we |-> o_scan_parent <= i_scan_addr);

endmodule

// ==== logic/blob_tally.sv ====
module blob_tally import blob_pkg::*; #(
    parameter int AREA_SHIFT = 3
) (
    input  logic   i_clk,
    input  logic   i_rst_n,
    input  logic   i_frame_end,
    input  label_t i_scan_parent,
    input  area_t  i_scan_area,
    output label_t o_scan_addr,
    output logic   o_merge_we,
    output logic   o_clear_we,
    output logic   o_busy,
    output logic   o_valid,
    output count_t o_count
);

    tally_state_e state_q;
    logic [8:0]   scan_q;
    area_t        max_q;
    count_t       cnt_q;
    count_t       count_q;   // last result, held for o_count

    logic   scan_last;
    logic   count_hit;
    count_t cnt_next;

    assign o_scan_addr = scan_q[LABEL_W-1:0];
    assign o_merge_we  = state_q == TALLY_MERGE;
    assign o_clear_we  = state_q == TALLY_COUNT;   // each entry cleared as it is read
    assign o_busy      = state_q != TALLY_IDLE;
    assign o_valid     = state_q == TALLY_OUT;
    assign o_count     = count_q;

    assign scan_last = scan_q == 9'(NUM_LABELS - 1);

    // only roots hold area after the merge
    assign count_hit = (o_scan_addr != '0) && (i_scan_parent == o_scan_addr)
                       && (i_scan_area > (max_q >> AREA_SHIFT));
    assign cnt_next  = cnt_q + count_t'(count_hit);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= TALLY_IDLE;
            scan_q  <= '0;
            max_q   <= '0;
            cnt_q   <= '0;
            count_q <= '0;
        end else begin
            case (state_q)
                TALLY_IDLE: begin
                    if (i_frame_end) begin
                        state_q <= TALLY_MERGE;
                        scan_q  <= 9'(NUM_LABELS - 1);
                        max_q   <= '0;
                        cnt_q   <= '0;
                    end
                end
                TALLY_MERGE: begin
                    if (scan_q == 9'd1) begin   // label 0 is never merged
                        state_q <= TALLY_MAX;
                        scan_q  <= '0;
                    end else begin
                        scan_q <= scan_q - 1'b1;
                    end
                end
                TALLY_MAX: begin
                    if (i_scan_area > max_q) begin
                        max_q <= i_scan_area;
                    end
                    if (scan_last) begin
                        state_q <= TALLY_COUNT;
                        scan_q  <= '0;
                    end else begin
                        scan_q <= scan_q + 1'b1;
                    end
                end
                TALLY_COUNT: begin
                    cnt_q <= cnt_next;
                    if (scan_last) begin
                        state_q <= TALLY_OUT;
                        count_q <= cnt_next;
                    end else begin
                        scan_q <= scan_q + 1'b1;
                    end
                end
                TALLY_OUT: begin
                    state_q <= TALLY_IDLE;
                end
                default: begin
                    state_q <= TALLY_IDLE;
                end
            endcase
        end
    end

    // stream must not end a frame while the table is being scanned
    a_frame_end_idle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_frame_end |-> state_q == TALLY_IDLE);

endmodule

// ==== logic/blob_counter.sv ====
module blob_counter import blob_pkg::*; #(
    parameter int IMG_COL    = 640,
    parameter int AREA_SHIFT = 3
) (
    input  logic   i_clk,
    input  logic   i_rst_n,
    input  logic   i_valid,
    input  logic   i_seq,
    output logic   o_busy,
    output logic   o_valid,
    output count_t o_count
);

    logic   new_we;
    logic   inc_we;
    logic   union_we;
    logic   frame_end;
    logic   merge_we;
    logic   clear_we;
    label_t new_label;
    label_t inc_label;
    label_t union_hi;
    label_t union_lo;
    label_t scan_addr;
    label_t scan_parent;
    area_t  scan_area;

    label_stream #(
        .IMG_COL(IMG_COL)
    ) i_label_stream (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_valid    (i_valid),
        .i_seq      (i_seq),
        .i_busy     (o_busy),       // pixels during the tally are dropped
        .o_new_we   (new_we),
        .o_inc_we   (inc_we),
        .o_union_we (union_we),
        .o_frame_end(frame_end),
        .o_new_label(new_label),
        .o_inc_label(inc_label),
        .o_union_hi (union_hi),
        .o_union_lo (union_lo)
    );

    label_table i_label_table (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_new_we     (new_we),
        .i_new_label  (new_label),
        .i_inc_we     (inc_we),
        .i_inc_label  (inc_label),
        .i_union_we   (union_we),
        .i_union_hi   (union_hi),
        .i_union_lo   (union_lo),
        .i_scan_addr  (scan_addr),
        .i_merge_we   (merge_we),
        .i_clear_we   (clear_we),
        .o_scan_parent(scan_parent),
        .o_scan_area  (scan_area)
    );

    blob_tally #(
        .AREA_SHIFT(AREA_SHIFT)
    ) i_blob_tally (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_frame_end  (frame_end),
        .i_scan_parent(scan_parent),
        .i_scan_area  (scan_area),
        .o_scan_addr  (scan_addr),
        .o_merge_we   (merge_we),
        .o_clear_we   (clear_we),
        .o_busy       (o_busy),
        .o_valid      (o_valid),
        .o_count      (o_count)
    );

endmodule

// ==== verif/blob_counter_tb.sv ====
module blob_counter_tb
    import blob_pkg::*;
();

    localparam int IMG_COL    = 16;
    localparam int AREA_SHIFT = 3;
    localparam int MAX_ROWS   = 12;
    localparam int TIMEOUT    = 2000;
    localparam int LATENCY    = 769;   // frame end cycle to result pulse

    logic   clk;
    logic   rst_n;
    logic   valid;
    logic   seq;
    logic   busy;
    logic   done;
    count_t count;

    logic [IMG_COL-1:0] img [MAX_ROWS];   // bit c is column c
    int seed         = 99;
    int errors       = 0;
    int tests_run    = 0;
    int tests_failed = 0;

    blob_counter #(
        .IMG_COL   (IMG_COL),
        .AREA_SHIFT(AREA_SHIFT)
    ) i_blob_counter (
        .i_clk  (clk),
        .i_rst_n(rst_n),
        .i_valid(valid),
        .i_seq  (seq),
        .o_busy (busy),
        .o_valid(done),
        .o_count(count)
    );

    always #50 clk = ~clk;

    task automatic check_count(input string name, input count_t exp, input count_t act);
        if (exp !== act) begin
            $display("[ERROR] %s: count expected %0d, actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_state(input string name, input tally_state_e exp,
                               input tally_state_e act);
        if (exp !== act) begin
            $display("[ERROR] %s: state expected %s, actual %s", name, exp.name(), act.name());
            errors++;
        end
    endtask

    task automatic check_cycles(input string name, input int exp, input int act);
        if (exp != act) begin
            $display("[ERROR] %s: latency expected %0d, actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("[ERROR] %s: flag expected %b, actual %b", name, exp, act);
            errors++;
        end
    endtask

    task automatic clear_image();
        for (int r = 0; r < MAX_ROWS; r++) begin
            img[r] = '0;
        end
    endtask

    task automatic set_rect(input int r0, input int c0, input int h, input int w);
        for (int r = r0; r < r0 + h; r++) begin
            for (int c = c0; c < c0 + w; c++) begin
                img[r][c] = 1'b1;
            end
        end
    endtask

    // 1x1 and 2x2 dots with an empty ring around each
    task automatic place_dots(input int tries);
        int r;
        int c;
        int s;
        bit free;
        for (int t = 0; t < tries; t++) begin
            r    = $unsigned($random(seed)) % MAX_ROWS;
            c    = $unsigned($random(seed)) % IMG_COL;
            s    = ($random(seed) & 1) ? 2 : 1;
            free = (r + s <= MAX_ROWS) && (c + s <= IMG_COL);
            for (int rr = r - 1; rr <= r + s; rr++) begin
                for (int cc = c - 1; cc <= c + s; cc++) begin
                    if (free && rr >= 0 && rr < MAX_ROWS && cc >= 0 && cc < IMG_COL) begin
                        if (img[rr][cc]) begin
                            free = 1'b0;
                        end
                    end
                end
            end
            if (free) begin
                set_rect(r, c, s, s);
            end
        end
    endtask

    task automatic send_frame(input int rows);
        for (int r = 0; r < rows; r++) begin
            for (int c = 0; c < IMG_COL; c++) begin
                @(posedge clk);
                valid <= 1'b1;
                seq   <= img[r][c];
            end
        end
        @(posedge clk);
        valid <= 1'b0;   // this idle cycle ends the frame
        seq   <= 1'b0;
    endtask

    // 4-connected flood fill over the stored image
    task automatic reference_count(input int rows, output count_t cnt);
        bit mark [MAX_ROWS][IMG_COL];
        int dr [4] = '{-1, 1, 0, 0};
        int dc [4] = '{0, 0, -1, 1};
        int areas [$];
        int stk [$];
        int pos;
        int pr;
        int pc;
        int nr;
        int nc;
        int a;
        int max_area;
        for (int r = 0; r < MAX_ROWS; r++) begin
            for (int c = 0; c < IMG_COL; c++) begin
                mark[r][c] = 1'b0;
            end
        end
        for (int r = 0; r < rows; r++) begin
            for (int c = 0; c < IMG_COL; c++) begin
                if (img[r][c] && !mark[r][c]) begin
                    mark[r][c] = 1'b1;
                    stk.push_back(r * IMG_COL + c);
                    a = 0;
                    while (stk.size() > 0) begin
                        pos = stk.pop_back();
                        pr  = pos / IMG_COL;
                        pc  = pos % IMG_COL;
                        a++;
                        for (int d = 0; d < 4; d++) begin
                            nr = pr + dr[d];
                            nc = pc + dc[d];
                            if (nr >= 0 && nr < rows && nc >= 0 && nc < IMG_COL) begin
                                if (img[nr][nc] && !mark[nr][nc]) begin
                                    mark[nr][nc] = 1'b1;
                                    stk.push_back(nr * IMG_COL + nc);
                                end
                            end
                        end
                    end
                    areas.push_back(a);
                end
            end
        end
        max_area = 0;
        foreach (areas[i]) begin
            if (areas[i] > max_area) max_area = areas[i];
        end
        cnt = '0;
        foreach (areas[i]) begin
            if (areas[i] > (max_area >> AREA_SHIFT)) cnt++;
        end
    endtask

    task automatic wait_result(output int cycles, output bit seen);
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
            seen = done;
        end
        if (!seen) begin
            $display("timeout: no result pulse within %0d cycles of frame end", TIMEOUT);
            errors++;
        end
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (busy && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (busy) begin
            $display("timeout: tally still busy after %0d cycles", TIMEOUT);
            errors++;
        end
    endtask

    task automatic run_frame(input string name, input int rows, output int cycles,
                             output bit seen);
        count_t exp;
        reference_count(rows, exp);
        send_frame(rows);
        wait_result(cycles, seen);
        if (seen) begin
            check_count(name, exp, count);
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        wait_idle();
        tests_run++;
        if (errors == err_before) begin
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: failed", name);
        end
    endtask

    task automatic test_reset();
        int e0;
        e0 = errors;
        @(negedge clk);
        check_state("reset", TALLY_IDLE, i_blob_counter.i_blob_tally.state_q);
        check_count("reset", '0, count);
        check_flag("reset", 1'b0, busy);
        check_flag("reset", 1'b0, done);
        end_test("reset", e0);
    endtask

    task automatic test_empty();
        int e0;
        int cyc;
        bit seen;
        e0 = errors;
        clear_image();
        run_frame("empty_frame", 4, cyc, seen);
        @(negedge clk);   // pulse is one cycle wide
        check_flag("empty_frame", 1'b0, done);
        check_flag("empty_frame", 1'b0, busy);
        check_state("empty_frame", TALLY_IDLE, i_blob_counter.i_blob_tally.state_q);
        end_test("empty_frame", e0);
    endtask

    task automatic test_shapes();
        int e0;
        int cyc;
        bit seen;
        e0 = errors;
        clear_image();
        set_rect(1, 0, 2, 3);
        set_rect(1, 6, 2, 3);
        set_rect(1, 12, 2, 3);
        run_frame("three_rects", 4, cyc, seen);
        end_test("three_rects", e0);
        e0 = errors;
        clear_image();
        set_rect(0, 2, 5, 2);   // arms of the U
        set_rect(0, 8, 5, 2);
        set_rect(5, 2, 1, 8);
        run_frame("u_shape", 6, cyc, seen);
        end_test("u_shape", e0);
    endtask

    task automatic test_threshold();
        int e0;
        int cyc;
        bit seen;
        e0 = errors;
        clear_image();
        set_rect(0, 0, 8, 8);
        set_rect(0, 10, 2, 4);   // area 8, not above 64 >> 3
        run_frame("threshold", 8, cyc, seen);
        wait_idle();
        clear_image();
        set_rect(0, 0, 8, 8);
        set_rect(0, 10, 3, 3);   // area 9
        run_frame("threshold", 8, cyc, seen);
        end_test("threshold", e0);
    endtask

    task automatic test_back_to_back();
        int e0;
        int cyc;
        bit seen;
        e0 = errors;
        place_dots(30);
        run_frame("back_to_back", MAX_ROWS, cyc, seen);
        wait_idle();
        clear_image();
        set_rect(2, 3, 4, 5);
        run_frame("back_to_back", 8, cyc, seen);
        end_test("back_to_back", e0);
    endtask

    task automatic test_random_dots();
        int e0;
        int cyc;
        bit seen;
        e0 = errors;
        clear_image();
        place_dots(40);
        run_frame("random_dots", MAX_ROWS, cyc, seen);
        if (seen) begin
            check_cycles("random_dots", LATENCY, cyc);
        end
        end_test("random_dots", e0);
    endtask

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        valid = 1'b0;
        seq   = 1'b0;
        clear_image();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        test_reset();
        test_empty();
        test_shapes();
        test_threshold();
        test_back_to_back();
        test_random_dots();
        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
logic/blob_pkg.sv
logic/label_stream.sv
logic/label_table.sv
logic/blob_tally.sv
logic/blob_counter.sv
verif/blob_counter_tb.sv

// ==== Bender.yml ====
package:
  name: blob_counter

sources:
  - logic/blob_pkg.sv
  - logic/label_stream.sv
  - logic/label_table.sv
  - logic/blob_tally.sv
  - logic/blob_counter.sv
  - target: test
    files:
      - verif/blob_counter_tb.sv
